//--- rtl/pipe_trace_pkg.sv
/*
 * Shared constants for the pipeline trace unit.
 * The stage count and the instruction width are fixed here. Id and cycle
 * widths are module parameters and are set by the top level.
 */

package pipe_trace_pkg;

    ////////////////////////////////////////////////////////////
    // Pipeline shape
    ////////////////////////////////////////////////////////////

    // Five-stage in-order CPU
    localparam int NUM_STAGES = 5;

    // Stage indices, also the slot order of the stamp vectors
    localparam int STG_FETCH   = 0;
    localparam int STG_DECODE  = 1;
    localparam int STG_EXECUTE = 2;
    localparam int STG_MEMORY  = 3;
    localparam int STG_WB      = 4;

    ////////////////////////////////////////////////////////////
    // Payload and counters
    ////////////////////////////////////////////////////////////

    // Instruction word as captured from the fetch port
    localparam int INSTR_W = 32;

    // Cycle counter value held during reset
    // All ones, so the first edge after release wraps it to 0
    localparam int CYCLE_RESET = -1;

endpackage

//--- rtl/trace_ifs.sv
/*
 * Internal buses of the trace unit.
 * stage_if carries per-stage occupancy from the tracker to the store.
 * record_if carries one completed record as a single-cycle pulse with no
 * ready signal; the receiver must always take or drop it.
 */

`timescale 1ns/100ps

interface stage_if #(
    parameter int ID_W    = 6,
    parameter int CYCLE_W = 16
);
    import pipe_trace_pkg::*;

    // One bit or one id per stage, indexed by STG_*
    logic [NUM_STAGES-1:0]           valid;
    logic [NUM_STAGES-1:0][ID_W-1:0] id;
    // High on the first cycle an instruction occupies the stage
    logic [NUM_STAGES-1:0]           enter;
    logic [CYCLE_W-1:0]              cycle;

    modport tracker (output valid, output id, output enter, output cycle);
    modport store   (input valid, input id, input enter, input cycle);

endinterface

interface record_if #(
    parameter int ID_W    = 6,
    parameter int CYCLE_W = 16
);
    import pipe_trace_pkg::*;

    logic                               rec_valid;
    logic [ID_W-1:0]                    rec_id;
    logic [INSTR_W-1:0]                 rec_instr;
    // Stage-entry cycle per stage, indexed by STG_*
    logic [NUM_STAGES-1:0][CYCLE_W-1:0] rec_stamp;

    modport store   (output rec_valid, output rec_id, output rec_instr, output rec_stamp);
    modport emitter (input rec_valid, input rec_id, input rec_instr, input rec_stamp);

endinterface

//--- rtl/stage_tracker.sv
/*
 * Follows sequence ids through fetch, decode, execute, memory and writeback.
 * A stall freezes every stage and ignores the fetch input. A flush, honoured
 * only without a stall, empties fetch and decode and discards the new fetch.
 * Ids count every accepted fetch, flushed or not, and wrap at 2**ID_W.
 */

`timescale 1ns/100ps

module stage_tracker #(
    parameter int ID_W    = 6,
    parameter int CYCLE_W = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     fetch_valid,
    input  logic     stall,
    input  logic     flush,
    stage_if.tracker stg
);
    import pipe_trace_pkg::*;

    logic [ID_W-1:0]       next_id;
    logic [NUM_STAGES-1:0] valid_nxt;

    ////////////////////////////////////////////////////////////
    // Occupancy for the next cycle, assuming no stall
    ////////////////////////////////////////////////////////////

    always_comb begin
        valid_nxt[STG_FETCH] = fetch_valid;
        for (int s = 1; s < NUM_STAGES; s++) begin
            valid_nxt[s] = stg.valid[s-1];
        end
        // Fetch and decode entries are dropped rather than moved on
        if (flush) begin
            valid_nxt[STG_FETCH]   = 1'b0;
            valid_nxt[STG_DECODE]  = 1'b0;
            valid_nxt[STG_EXECUTE] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stg.valid <= '0;
            stg.enter <= '0;
            stg.cycle <= CYCLE_W'(CYCLE_RESET);
            next_id   <= '0;
        end else begin
            // Free running, stalls do not hold it
            stg.cycle <= stg.cycle + 1'b1;
            if (!stall) begin
                stg.valid <= valid_nxt;
                stg.enter <= valid_nxt;
                if (fetch_valid) begin
                    next_id <= next_id + 1'b1;
                end
            end else begin
                stg.enter <= '0;
            end
        end
    end

    // Id shift register, only meaningful where valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            stg.id[STG_FETCH] <= next_id;
            for (int s = 1; s < NUM_STAGES; s++) begin
                stg.id[s] <= stg.id[s-1];
            end
        end
    end

endmodule

//--- rtl/trace_store.sv
/*
 * Collects stage-entry stamps and the instruction word per sequence id.
 * The table has 2**ID_W entries and must be larger than the five
 * instructions in flight. One record leaves, one cycle after an
 * instruction enters writeback, as a pulse on record_if.
 */

`timescale 1ns/100ps

module trace_store #(
    parameter int ID_W    = 6,
    parameter int CYCLE_W = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pipe_trace_pkg::INSTR_W-1:0] fetch_instr,
    stage_if.store                        stg,
    record_if.store                       rec
);
    import pipe_trace_pkg::*;

    localparam int ENTRIES = 2**ID_W;
    // Writeback stamp goes straight into the record, never into the table
    localparam int TAB_STAGES = NUM_STAGES - 1;

    logic [INSTR_W-1:0] instr_q;
    logic [INSTR_W-1:0] instr_tab [ENTRIES];
    logic [CYCLE_W-1:0] stamp_tab [ENTRIES][TAB_STAGES];
    logic [ID_W-1:0]    wb_id;
    logic               wb_hit;

    assign wb_id  = stg.id[STG_WB];
    assign wb_hit = stg.valid[STG_WB] && stg.enter[STG_WB];

    // Word seen at the last edge
    // When fetch is entered this is the word the tracker accepted
    always_ff @(posedge clk) begin
        instr_q <= fetch_instr;
    end

    ////////////////////////////////////////////////////////////
    // Table writes, one stamp port per stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stg.valid[STG_FETCH] && stg.enter[STG_FETCH]) begin
            instr_tab[stg.id[STG_FETCH]] <= instr_q;
        end
        for (int s = 0; s < TAB_STAGES; s++) begin
            if (stg.valid[s] && stg.enter[s]) begin
                stamp_tab[stg.id[s]][s] <= stg.cycle;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Record readout on writeback entry
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            rec.rec_valid <= 1'b0;
        end else begin
            rec.rec_valid <= wb_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_hit) begin
            rec.rec_id    <= wb_id;
            rec.rec_instr <= instr_tab[wb_id];
            for (int s = 0; s < TAB_STAGES; s++) begin
                rec.rec_stamp[s] <= stamp_tab[wb_id][s];
            end
            rec.rec_stamp[STG_WB] <= stg.cycle;
        end
    end

endmodule

//--- rtl/trace_emitter.sv
/*
 * Record queue with credit-based output. One beat per cycle while a credit
 * is held; an empty queue passes an arriving record straight through.
 * A record that finds the queue full with no pop that cycle is dropped and
 * counted. QUEUE_DEPTH must be at least 2; the host returns credits only.
 */

`timescale 1ns/100ps

module trace_emitter #(
    parameter int ID_W        = 6,
    parameter int CYCLE_W     = 16,
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDITS     = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    record_if.emitter                          rec,
    input  logic                               trace_credit,
    output logic                               trace_valid,
    output logic [ID_W-1:0]                    trace_id,
    output logic [pipe_trace_pkg::INSTR_W-1:0] trace_instr,
    output logic [CYCLE_W-1:0]                 trace_stamp_fetch,
    output logic [CYCLE_W-1:0]                 trace_stamp_decode,
    output logic [CYCLE_W-1:0]                 trace_stamp_execute,
    output logic [CYCLE_W-1:0]                 trace_stamp_memory,
    output logic [CYCLE_W-1:0]                 trace_stamp_wb,
    output logic [CYCLE_W-1:0]                 drop_count
);
    import pipe_trace_pkg::*;

    localparam int PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(CREDITS + 1);

    logic [ID_W-1:0]                    q_id    [QUEUE_DEPTH];
    logic [INSTR_W-1:0]                 q_instr [QUEUE_DEPTH];
    logic [NUM_STAGES-1:0][CYCLE_W-1:0] q_stamp [QUEUE_DEPTH];
    logic [NUM_STAGES-1:0][CYCLE_W-1:0] out_stamp;

    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credit_cnt;
    logic can_send, pop, bypass, push, drop, beat;

    ////////////////////////////////////////////////////////////
    // Beat, push and drop decisions
    ////////////////////////////////////////////////////////////

    assign can_send = (credit_cnt != '0);
    assign pop      = can_send && (count != '0);
    assign bypass   = can_send && (count == '0) && rec.rec_valid;
    assign beat     = pop || bypass;
    // A pop in the same cycle frees the slot the new record needs
    assign push     = rec.rec_valid && !bypass && ((count != CNT_W'(QUEUE_DEPTH)) || pop);
    assign drop     = rec.rec_valid && !bypass && !push;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            credit_cnt  <= CRED_W'(CREDITS);
            drop_count  <= '0;
            trace_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count       <= count + CNT_W'(push) - CNT_W'(pop);
            credit_cnt  <= credit_cnt + CRED_W'(trace_credit) - CRED_W'(beat);
            drop_count  <= drop_count + CYCLE_W'(drop);
            trace_valid <= beat;
        end
    end

    ////////////////////////////////////////////////////////////
    // Queue storage and output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            q_id[wr_ptr]    <= rec.rec_id;
            q_instr[wr_ptr] <= rec.rec_instr;
            q_stamp[wr_ptr] <= rec.rec_stamp;
        end
        if (pop) begin
            trace_id    <= q_id[rd_ptr];
            trace_instr <= q_instr[rd_ptr];
            out_stamp   <= q_stamp[rd_ptr];
        end else if (bypass) begin
            trace_id    <= rec.rec_id;
            trace_instr <= rec.rec_instr;
            out_stamp   <= rec.rec_stamp;
        end
    end

    assign trace_stamp_fetch   = out_stamp[STG_FETCH];
    assign trace_stamp_decode  = out_stamp[STG_DECODE];
    assign trace_stamp_execute = out_stamp[STG_EXECUTE];
    assign trace_stamp_memory  = out_stamp[STG_MEMORY];
    assign trace_stamp_wb      = out_stamp[STG_WB];

endmodule

//--- rtl/pipe_trace_top.sv
/*
 * Instruction trace unit for a five-stage in-order pipeline.
 * Without stalls a record appears 6 cycles after its fetch edge.
 * Records beyond the queue and the held credits are dropped, never stalled.
 */

`timescale 1ns/100ps

module pipe_trace_top #(
    parameter int ID_W        = 6,
    parameter int CYCLE_W     = 16,
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDITS     = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               fetch_valid,
    input  logic [pipe_trace_pkg::INSTR_W-1:0] fetch_instr,
    input  logic                               stall,
    input  logic                               flush,
    input  logic                               trace_credit,
    output logic                               trace_valid,
    output logic [ID_W-1:0]                    trace_id,
    output logic [pipe_trace_pkg::INSTR_W-1:0] trace_instr,
    output logic [CYCLE_W-1:0]                 trace_stamp_fetch,
    output logic [CYCLE_W-1:0]                 trace_stamp_decode,
    output logic [CYCLE_W-1:0]                 trace_stamp_execute,
    output logic [CYCLE_W-1:0]                 trace_stamp_memory,
    output logic [CYCLE_W-1:0]                 trace_stamp_wb,
    output logic [CYCLE_W-1:0]                 drop_count
);

    stage_if  #(.ID_W(ID_W), .CYCLE_W(CYCLE_W)) stg_bus ();
    record_if #(.ID_W(ID_W), .CYCLE_W(CYCLE_W)) rec_bus ();

    stage_tracker #(.ID_W(ID_W), .CYCLE_W(CYCLE_W)) stage_tracker_i (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid),
        .stall(stall), .flush(flush), .stg(stg_bus)
    );

    trace_store #(.ID_W(ID_W), .CYCLE_W(CYCLE_W)) trace_store_i (
        .clk(clk), .rst(rst), .fetch_instr(fetch_instr),
        .stg(stg_bus), .rec(rec_bus)
    );

    trace_emitter #(
        .ID_W(ID_W), .CYCLE_W(CYCLE_W), .QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)
    ) trace_emitter_i (
        .clk(clk), .rst(rst), .rec(rec_bus), .trace_credit(trace_credit),
        .trace_valid(trace_valid), .trace_id(trace_id), .trace_instr(trace_instr),
        .trace_stamp_fetch(trace_stamp_fetch), .trace_stamp_decode(trace_stamp_decode),
        .trace_stamp_execute(trace_stamp_execute), .trace_stamp_memory(trace_stamp_memory),
        .trace_stamp_wb(trace_stamp_wb), .drop_count(drop_count)
    );

endmodule

//--- verification/pipe_trace_assertions.sv
/*
 * Protocol checks on the trace output of every trace_emitter instance.
 * Credit width follows the emitter's own sizing rule for CREDITS.
 * The credit check counts beats and credit pulses at the pins only.
 */

`timescale 1ns/100ps

module pipe_trace_assertions #(
    parameter int CYCLE_W = 16,
    parameter int CREDITS = 2,
    parameter int CRED_W  = $clog2(CREDITS + 1)
) (
    input logic              clk,
    input logic              rst,
    input logic              trace_valid,
    input logic              trace_credit,
    input logic [CRED_W-1:0] credit_cnt,
    input logic [CYCLE_W-1:0] drop_count
);

    // Beats the host has not yet answered with a credit pulse
    int outstanding;

    always_ff @(posedge clk) begin
        if (!rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(trace_valid) - int'(trace_credit);
        end
    end

    // Output beat is cleared by every reset edge
    valid_low_in_reset: assert property (@(posedge clk) !rst |=> !trace_valid)
        else $error("trace_valid high after a reset edge");

    beat_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        outstanding + int'(trace_valid) <= CREDITS)
        else $error("more beats sent than credits granted and returned");

    credit_in_range: assert property (@(posedge clk) disable iff (!rst)
        credit_cnt <= CRED_W'(CREDITS))
        else $error("credit count above the reset grant");

    // Only reset may lower the drop counter
    drops_monotonic: assert property (@(posedge clk)
        rst && $past(rst) |-> drop_count >= $past(drop_count))
        else $error("drop_count decreased without reset");

endmodule

bind trace_emitter pipe_trace_assertions #(
    .CYCLE_W(CYCLE_W), .CREDITS(CREDITS)
) trace_emitter_checks (
    .clk(clk), .rst(rst), .trace_valid(trace_valid), .trace_credit(trace_credit),
    .credit_cnt(credit_cnt), .drop_count(drop_count)
);

//--- verification/pipe_trace_tb.sv
/*
 * Testbench for the pipeline trace unit with the DUT at default parameters.
 * A behavioural pipeline and emitter model steps on each falling edge
 * with the inputs the next rising edge will sample.
 */

`timescale 1ns/100ps

module pipe_trace_tb;
    import pipe_trace_pkg::*;

    localparam int ID_W        = 6;
    localparam int CYCLE_W     = 16;
    localparam int QUEUE_DEPTH = 4;
    localparam int CREDITS     = 2;
    localparam int DRAIN_MAX   = 40;
    // Summed test lengths of 330 plus six drains and a margin
    localparam int WATCHDOG_CYCLES = 330 + 6 * DRAIN_MAX + 100;

    typedef struct packed {
        logic [ID_W-1:0]                    id;
        logic [INSTR_W-1:0]                 instr;
        logic [NUM_STAGES-1:0][CYCLE_W-1:0] stamp;
    } trace_rec_t;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic fetch_valid = 1'b0;
    logic [INSTR_W-1:0] fetch_instr = '0;
    logic stall = 1'b0;
    logic flush = 1'b0;
    logic trace_credit = 1'b0;
    logic trace_valid;
    logic [ID_W-1:0] trace_id;
    logic [INSTR_W-1:0] trace_instr;
    logic [CYCLE_W-1:0] trace_stamp_fetch, trace_stamp_decode, trace_stamp_execute;
    logic [CYCLE_W-1:0] trace_stamp_memory, trace_stamp_wb, drop_count;

    // Model state stepped by the falling-edge process
    trace_rec_t            slot [NUM_STAGES];
    logic [NUM_STAGES-1:0] slot_v = '0;
    trace_rec_t            p1, p2;
    logic                  p1_v = 1'b0;
    logic                  p2_v = 1'b0;
    trace_rec_t            emit_q [$];
    trace_rec_t            exp_q [$];
    logic [CYCLE_W-1:0]    m_cycle = '1;
    logic [ID_W-1:0]       m_next_id = '0;
    logic [CYCLE_W-1:0]    m_drops = '0;
    logic                  m_out_v = 1'b0;
    int                    m_credits = CREDITS;

    logic [31:0] lfsr = 32'h849c_9bb7;
    int cur_test = 0;
    int beats = 0;
    int checks = 0;
    int err_cmp = 0;
    int err_seq = 0;

    pipe_trace_top pipe_trace_top_i (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
        .stall(stall), .flush(flush), .trace_credit(trace_credit),
        .trace_valid(trace_valid), .trace_id(trace_id), .trace_instr(trace_instr),
        .trace_stamp_fetch(trace_stamp_fetch), .trace_stamp_decode(trace_stamp_decode),
        .trace_stamp_execute(trace_stamp_execute), .trace_stamp_memory(trace_stamp_memory),
        .trace_stamp_wb(trace_stamp_wb), .drop_count(drop_count)
    );

    always #5 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model of one rising edge
    ////////////////////////////////////////////////////////////

    function automatic void model_edge();
        trace_rec_t fresh;
        trace_rec_t beat_rec;
        logic arr_v;
        logic beat_v;
        if (!rst) begin
            slot_v = '0;
            p1_v = 1'b0;
            p2_v = 1'b0;
            emit_q.delete();
            exp_q.delete();
            m_cycle = '1;
            m_next_id = '0;
            m_drops = '0;
            m_out_v = 1'b0;
            m_credits = CREDITS;
            return;
        end
        m_cycle = m_cycle + 16'd1;
        // Emitter sees the record that was pulsed during the last cycle
        arr_v = p2_v;
        beat_v = 1'b0;
        beat_rec = '0;
        if (m_credits > 0) begin
            if (emit_q.size() > 0) begin
                beat_rec = emit_q.pop_front();
                beat_v = 1'b1;
            end else if (arr_v) begin
                beat_rec = p2;
                beat_v = 1'b1;
                arr_v = 1'b0;
            end
        end
        if (arr_v) begin
            if (emit_q.size() < QUEUE_DEPTH) begin
                emit_q.push_back(p2);
            end else begin
                m_drops = m_drops + 16'd1;
            end
        end
        m_credits = m_credits + (trace_credit ? 1 : 0) - (beat_v ? 1 : 0);
        m_out_v = beat_v;
        if (beat_v) begin
            exp_q.push_back(beat_rec);
        end
        p2_v = p1_v;
        p2 = p1;
        p1_v = 1'b0;
        if (!stall) begin
            if (slot_v[STG_MEMORY]) begin
                p1_v = 1'b1;
                p1 = slot[STG_MEMORY];
                p1.stamp[STG_WB] = m_cycle;
            end
            for (int s = NUM_STAGES - 1; s > 0; s--) begin
                slot_v[s] = slot_v[s-1] && !(flush && s <= STG_EXECUTE);
                slot[s] = slot[s-1];
                slot[s].stamp[s] = m_cycle;
            end
            fresh = '0;
            fresh.id = m_next_id;
            fresh.instr = fetch_instr;
            fresh.stamp[STG_FETCH] = m_cycle;
            slot[STG_FETCH] = fresh;
            slot_v[STG_FETCH] = fetch_valid && !flush;
            if (fetch_valid) begin
                m_next_id = m_next_id + 6'd1;
            end
        end
    endfunction

    function automatic logic model_idle();
        return slot_v == '0 && !p1_v && !p2_v && emit_q.size() == 0
            && exp_q.size() == 0 && !m_out_v;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_beat(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            err_cmp++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] got,
                            input logic [ID_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            err_cmp++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_W-1:0] got,
                               input logic [INSTR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            err_cmp++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stamp(input string name, input logic [CYCLE_W-1:0] got,
                               input logic [CYCLE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            err_cmp++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [CYCLE_W-1:0] got,
                               input logic [CYCLE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            err_cmp++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Outputs are stable at the falling edge before the model takes one step
    always @(negedge clk) begin : compare_outputs
        trace_rec_t r;
        check_beat("trace_valid", trace_valid, m_out_v);
        if (trace_valid === 1'b1) begin
            beats++;
            if (exp_q.size() == 0) begin
                err_cmp++;
                $display("Record beat at %0t with no record expected", $time);
            end else begin
                r = exp_q.pop_front();
                check_id("trace_id", trace_id, r.id);
                check_instr("trace_instr", trace_instr, r.instr);
                check_stamp("trace_stamp_fetch", trace_stamp_fetch, r.stamp[STG_FETCH]);
                check_stamp("trace_stamp_decode", trace_stamp_decode, r.stamp[STG_DECODE]);
                check_stamp("trace_stamp_execute", trace_stamp_execute, r.stamp[STG_EXECUTE]);
                check_stamp("trace_stamp_memory", trace_stamp_memory, r.stamp[STG_MEMORY]);
                check_stamp("trace_stamp_wb", trace_stamp_wb, r.stamp[STG_WB]);
                if (cur_test == 1) begin
                    check_stamp("trace_stamp_wb - trace_stamp_fetch",
                                trace_stamp_wb - trace_stamp_fetch, 16'd4);
                end
            end
        end
        check_count("drop_count", drop_count, m_drops);
        model_edge();
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic rst_n, input logic fv, input logic st,
                               input logic fl, input logic cr);
        @(posedge clk);
        #1;
        rst = rst_n;
        fetch_valid = fv;
        fetch_instr = take_bits(32);
        stall = st;
        flush = fl;
        // Credits return only for beats already received
        trace_credit = cr && (m_credits < CREDITS);
    endtask

    task automatic run_test(input int num, input string name, input int cycles);
        logic fv, st, fl, cr, rn;
        int waited;
        logic [CYCLE_W-1:0] drops_before;
        cur_test = num;
        drops_before = drop_count;
        for (int i = 0; i < cycles; i++) begin
            fv = 1'b1;
            st = 1'b0;
            fl = 1'b0;
            cr = 1'b1;
            rn = 1'b1;
            case (num)
                2: begin
                    fv = (take_bits(2) != 0);
                    st = (take_bits(2) == 0);
                end
                3: fl = (take_bits(3) == 0);
                4: begin
                    fv = (take_bits(1) != 0);
                    cr = ((i % 16) >= 8);
                end
                5: cr = (i >= 40);
                6: begin
                    fv = (take_bits(2) != 0);
                    st = (take_bits(3) == 0);
                    fl = (take_bits(3) == 0);
                    rn = !(i == 20 || i == 21);
                end
                default: ;
            endcase
            drive_cycle(rn, fv, st, fl, cr);
        end
        waited = 0;
        while (!model_idle() && waited < DRAIN_MAX) begin
            drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
            waited++;
        end
        if (!model_idle()) begin
            err_seq++;
            $display("Test %0d did not drain within %0d cycles", num, DRAIN_MAX);
        end
        if (num == 5 && drop_count == drops_before) begin
            err_seq++;
            $display("Test 5 starved the queue but drop_count stayed at %0d", drop_count);
        end
        $display("Test %0d (%s) finished after %0d cycles, %0d records checked so far",
                 num, name, cycles + waited, beats);
    endtask

    initial begin
        // The first reset edge samples the initial values and this is the second
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test(1, "free flow", 40);
        run_test(2, "stalls", 60);
        run_test(3, "flushes", 60);
        run_test(4, "credit back-pressure", 60);
        run_test(5, "queue overflow", 60);
        run_test(6, "mid-run reset", 50);
        @(negedge clk);
        #1;
        $display("Summary: 6 tests, %0d records, %0d checks, %0d errors",
                 beats, checks, err_cmp + err_seq);
        if (err_cmp + err_seq == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- sources.f
rtl/pipe_trace_pkg.sv
rtl/trace_ifs.sv
rtl/stage_tracker.sv
rtl/trace_store.sv
rtl/trace_emitter.sv
rtl/pipe_trace_top.sv
verification/pipe_trace_assertions.sv
verification/pipe_trace_tb.sv

//--- Makefile
# Verilator build and run for the pipeline trace unit

SIM := obj_dir/Vpipe_trace_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): sources.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert -f sources.f --top-module pipe_trace_tb -Mdir obj_dir

# Passes only if the testbench printed its pass line
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

clean:
	rm -rf obj_dir
